// File: Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --assert -j 0
TOP       = sdram_scheduler_tb
FILELIST  = compile.f
OBJ_DIR   = obj_dir
PASS_MSG  = No errors

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: compile.f
+incdir+verilog
verilog/sdram_pkg.sv
verilog/sdram_request_decode.sv
verilog/sdram_command_execute.sv
verilog/sdram_command_result.sv
verilog/sdram_scheduler.sv
test/sdram_scheduler_assertions.sv
test/sdram_scheduler_tb.sv

// File: test/sdram_scheduler_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module sdram_scheduler_assertions
  import sdram_pkg::*;
(
  input wire             INPUT_CLK,
  input wire             RST,
  input wire sdram_cmd_t cmd,
  input wire             rand_ready,
  input wire             bulk_ready
);

  // ------------------------------
  // Result stage properties
  // ------------------------------
  one_ready: assert property (@(posedge INPUT_CLK) disable iff (!RST)
    !(rand_ready && bulk_ready))
    else $error("rand_ready and bulk_ready high together");

  ready_on_access: assert property (@(posedge INPUT_CLK) disable iff (!RST)
    (rand_ready || bulk_ready) |-> (cmd == READ || cmd == WRTE))
    else $error("Ready without READ or WRTE");

  // At least one NOOP after each command
  noop_between: assert property (@(posedge INPUT_CLK) disable iff (!RST)
    (cmd != NOOP) |=> (cmd == NOOP))
    else $error("Back to back commands");

endmodule

bind sdram_command_result sdram_scheduler_assertions u_assert (
  .INPUT_CLK  (INPUT_CLK),
  .RST        (RST),
  .cmd        (cmd),
  .rand_ready (rand_ready),
  .bulk_ready (bulk_ready)
);

`default_nettype wire

// File: test/sdram_scheduler_tb.sv
`timescale 1ns/1ps
`default_nettype none
`include "sdram_params.svh"

module sdram_scheduler_tb
  import sdram_pkg::*;
();

  localparam int RUN_CYCLES  = 6000;
  localparam int REQ_LIMIT   = 400;   // Cycles a request may wait
  localparam int REF_LIMIT   = 100;
  localparam int DRAIN_LIMIT = 1000;

  logic                   INPUT_CLK;
  logic                   RST;
  logic                   refresh_strobe;
  logic                   rand_valid;
  logic                   rand_we;
  logic                   bulk_valid;
  logic                   bulk_we;
  req_addr_t              rand_addr;
  req_addr_t              bulk_addr;
  logic                   rand_ready;
  logic                   bulk_ready;
  sdram_cmd_t             cmd;
  logic [`CMD_ADDR_W-1:0] cmd_addr;
  logic [`BANK_W-1:0]     cmd_bank;

  integer             seed;
  integer             err [0:5];   // Reset, protocol, gap, grant, priority, refresh
  integer             rand_gap, bulk_gap, ref_gap, rand_age, bulk_age, ref_age, ref_owed;
  integer             n_rand, n_bulk, n_ref, m_idle, i, total;
  logic               running, checking, m_open, m_first, bv_d1, bv_d2;
  logic [`PAGE_W-1:0] m_page;
  sdram_cmd_t         m_last;
  req_addr_t          a_tmp;
  logic               w_tmp;

  sdram_scheduler uut (
    .INPUT_CLK (INPUT_CLK), .RST (RST), .refresh_strobe (refresh_strobe),
    .rand_valid (rand_valid), .rand_addr (rand_addr), .rand_we (rand_we),
    .rand_ready (rand_ready),
    .bulk_valid (bulk_valid), .bulk_addr (bulk_addr), .bulk_we (bulk_we),
    .bulk_ready (bulk_ready),
    .cmd (cmd), .cmd_addr (cmd_addr), .cmd_bank (cmd_bank)
  );

  always #10 INPUT_CLK = ~INPUT_CLK;

  // Idle cycles the SDRAM needs after prev before nxt
  function automatic integer min_gap(input sdram_cmd_t prev, input sdram_cmd_t nxt);
    case (prev)
      ACTV:    min_gap = `T_RCD;
      PRCH:    min_gap = `T_RP;
      ARSR:    min_gap = `T_RFC;
      WRTE:    min_gap = (nxt == PRCH) ? `T_WR : `T_RW;
      default: min_gap = `T_RW;
    endcase
  endfunction

  // Four pages only, so hits and misses both occur
  task automatic draw_request(output req_addr_t a, output logic we);
    logic [31:0] r;
    r = $random(seed);
    a = '0;
    a.fields.row    = {11'd0, r[0]};
    a.fields.bank   = {1'b0, r[1]};
    a.fields.column = r[13:2];
    we = r[14];
  endtask

  task automatic check_reset_outputs();
    if (cmd != NOOP)
    begin
      $display("MISMATCH cmd in reset: got %h expected %h", cmd, NOOP);
      err[0] = err[0] + 1;
    end
    if (rand_ready)
    begin
      $display("MISMATCH rand_ready in reset: got %h expected %h", rand_ready, 1'b0);
      err[0] = err[0] + 1;
    end
    if (bulk_ready)
    begin
      $display("MISMATCH bulk_ready in reset: got %h expected %h", bulk_ready, 1'b0);
      err[0] = err[0] + 1;
    end
    if (cmd_addr != 13'h0400)
    begin
      $display("MISMATCH cmd_addr in reset: got %h expected %h", cmd_addr, 13'h0400);
      err[0] = err[0] + 1;
    end
  endtask

  task automatic check_grant(input logic valid, input req_addr_t a, input logic we);
    logic [`CMD_ADDR_W-1:0] col_addr;
    col_addr = {1'b0, a.fields.column} << 1;
    if (!valid)
    begin
      $display("Ready raised with no request outstanding");
      err[3] = err[3] + 1;
    end
    if (cmd != (we ? WRTE : READ))
    begin
      $display("MISMATCH cmd at grant: got %h expected %h", cmd, we ? WRTE : READ);
      err[3] = err[3] + 1;
    end
    if (!m_open || m_page != a.paged.page)
    begin
      $display("MISMATCH open page at grant: got %h expected %h", m_page, a.paged.page);
      err[3] = err[3] + 1;
    end
    if (cmd_addr != col_addr)
    begin
      $display("MISMATCH cmd_addr at grant: got %h expected %h", cmd_addr, col_addr);
      err[3] = err[3] + 1;
    end
  endtask

  always @(posedge INPUT_CLK)
  begin
    if (checking)
    begin
      // ------------------------------
      // Protocol model
      // ------------------------------
      if (m_first && cmd != NOOP)
      begin
        if (cmd == READ || cmd == WRTE)
        begin
          $display("First command after reset is an access: %h", cmd);
          err[0] = err[0] + 1;
        end
        m_first = 1'b0;
      end
      case (cmd)
        ACTV: if (m_open)
        begin
          $display("ACTV issued while a page is open");
          err[1] = err[1] + 1;
        end
        PRCH:
        begin
          if (!m_open)
          begin
            $display("PRCH issued with no page open");
            err[1] = err[1] + 1;
          end
          if (cmd_addr != 13'h0400)
          begin
            $display("MISMATCH cmd_addr on PRCH: got %h expected %h", cmd_addr, 13'h0400);
            err[1] = err[1] + 1;
          end
        end
        ARSR:
        begin
          if (m_open)
          begin
            $display("ARSR issued while a page is open");
            err[1] = err[1] + 1;
          end
          if (ref_owed == 0)
          begin
            $display("ARSR issued with no refresh toggle pending");
            err[5] = err[5] + 1;
          end
          else
            ref_owed = ref_owed - 1;
          n_ref = n_ref + 1;
        end
        READ, WRTE:
        begin
          if (!m_open)
          begin
            $display("Access issued with no page open");
            err[1] = err[1] + 1;
          end
          if (cmd_bank != m_page[`BANK_W-1:0])
          begin
            $display("MISMATCH cmd_bank on access: got %h expected %h", cmd_bank, m_page[1:0]);
            err[1] = err[1] + 1;
          end
        end
        default: ;
      endcase
      if (cmd != NOOP)
      begin
        if (m_last != NOOP && m_idle < min_gap(m_last, cmd))
        begin
          $display("Only %0d idle cycles between %h and %h", m_idle, m_last, cmd);
          err[2] = err[2] + 1;
        end
        m_last = cmd;
        m_idle = 0;
      end
      else
        m_idle = m_idle + 1;

      // ------------------------------
      // Grants and priority
      // ------------------------------
      if (rand_ready && bulk_ready)
      begin
        $display("Both readies high in one cycle");
        err[3] = err[3] + 1;
      end
      if (rand_ready)
      begin
        check_grant(rand_valid, rand_addr, rand_we);
        n_rand = n_rand + 1;
      end
      if (bulk_ready)
      begin
        check_grant(bulk_valid, bulk_addr, bulk_we);
        n_bulk = n_bulk + 1;
      end
      if (bv_d1 && bv_d2 && rand_ready)
      begin
        $display("Random port granted while bulk request was waiting");
        err[4] = err[4] + 1;
      end
      bv_d2 = bv_d1;
      bv_d1 = bulk_valid;
      if (cmd == ACTV)
      begin
        m_open = 1'b1;
        m_page = {cmd_addr[`ROW_W-1:0], cmd_bank};
      end
      if (cmd == PRCH)
        m_open = 1'b0;

      rand_age = (rand_valid && !rand_ready) ? rand_age + 1 : 0;
      bulk_age = (bulk_valid && !bulk_ready) ? bulk_age + 1 : 0;
      ref_age  = (ref_owed > 0) ? ref_age + 1 : 0;
      if (rand_age == REQ_LIMIT || bulk_age == REQ_LIMIT)
      begin
        $display("Request not granted within %0d cycles", REQ_LIMIT);
        err[3] = err[3] + 1;
      end
      if (ref_age == REF_LIMIT)
      begin
        $display("Refresh toggle not served within %0d cycles", REF_LIMIT);
        err[5] = err[5] + 1;
      end
    end

    // ------------------------------
    // Stimulus
    // ------------------------------
    if (rand_valid)
    begin
      if (rand_ready)
      begin
        rand_valid <= 1'b0;
        rand_gap = $random(seed) & 7;
      end
    end
    else if (rand_gap > 0)
      rand_gap = rand_gap - 1;
    else if (running)
    begin
      draw_request(a_tmp, w_tmp);
      rand_valid <= 1'b1;
      rand_addr  <= a_tmp;
      rand_we    <= w_tmp;
    end
    if (bulk_valid)
    begin
      if (bulk_ready)
      begin
        bulk_valid <= 1'b0;
        bulk_gap = 20 + ($random(seed) & 15);   // Leaves room for the random port
      end
    end
    else if (bulk_gap > 0)
      bulk_gap = bulk_gap - 1;
    else if (running)
    begin
      draw_request(a_tmp, w_tmp);
      bulk_valid <= 1'b1;
      bulk_addr  <= a_tmp;
      bulk_we    <= w_tmp;
    end
    if (ref_owed == 0)
    begin
      if (ref_gap > 0)
        ref_gap = ref_gap - 1;
      else if (running)
      begin
        refresh_strobe <= ~refresh_strobe;
        ref_owed = 1;
        ref_gap  = 20 + ($random(seed) & 63);
      end
    end
  end

  initial
  begin
    seed = 32'h36a8bce5;
    INPUT_CLK = 1'b0;
    RST = 1'b0;
    refresh_strobe = 1'b0;
    rand_valid = 1'b0;
    rand_we = 1'b0;
    rand_addr = '0;
    bulk_valid = 1'b0;
    bulk_we = 1'b0;
    bulk_addr = '0;
    running = 1'b0;
    checking = 1'b0;
    m_open = 1'b0;
    m_first = 1'b1;
    m_page = '0;
    m_last = NOOP;
    m_idle = 0;
    bv_d1 = 1'b0;
    bv_d2 = 1'b0;
    {rand_gap, bulk_gap, ref_gap, rand_age, bulk_age, ref_age, ref_owed} = '0;
    {n_rand, n_bulk, n_ref} = '0;
    for (i = 0; i < 6; i = i + 1)
      err[i] = 0;

    @(posedge INPUT_CLK);
    @(posedge INPUT_CLK);
    check_reset_outputs();
    RST <= 1'b1;
    @(posedge INPUT_CLK);
    check_reset_outputs();   // Values registered on the last reset edge
    checking <= 1'b1;
    running  <= 1'b1;

    for (i = 0; i < RUN_CYCLES; i = i + 1)
      @(posedge INPUT_CLK);
    running <= 1'b0;
    i = 0;
    @(negedge INPUT_CLK);
    while ((rand_valid || bulk_valid || ref_owed > 0) && i < DRAIN_LIMIT)
    begin
      @(negedge INPUT_CLK);
      i = i + 1;
    end
    if (i == DRAIN_LIMIT)
    begin
      $display("Timeout waiting for open requests and refreshes to finish");
      err[3] = err[3] + 1;
    end

    $display("Reset state:        %0d errors", err[0]);
    $display("Protocol legality:  %0d errors", err[1]);
    $display("Command gaps:       %0d errors", err[2]);
    $display("Grants:             %0d errors", err[3]);
    $display("Priority:           %0d errors", err[4]);
    $display("Refresh:            %0d errors", err[5]);
    total = err[0] + err[1] + err[2] + err[3] + err[4] + err[5];
    $display("Totals: %0d random grants, %0d bulk grants, %0d refreshes, %0d errors",
             n_rand, n_bulk, n_ref, total);
    if (total == 0)
      $display("No errors");
    else
      $display("Errors found");
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog/sdram_command_execute.sv
`timescale 1ns/1ps
`default_nettype none
`include "sdram_params.svh"

module sdram_command_execute
  import sdram_pkg::*;
(
  input  wire                    INPUT_CLK,
  input  wire                    RST,
  input  wire                    refresh_strobe,
  input  wire                    sel_valid,
  input  wire                    sel_bulk,
  input  wire                    sel_we,
  input  wire                    page_hit,
  input  wire req_addr_t         sel_addr,
  output logic                   issue,
  output sdram_cmd_t             next_cmd,
  output logic [`CMD_ADDR_W-1:0] next_addr,
  output logic [`BANK_W-1:0]     next_bank,
  output logic [`PAGE_W-1:0]     open_page,
  output logic                   page_open,
  output logic                   issue_bulk
);

  localparam int GAP_W = 4;   // Holds T_RFC

  logic             strobe_q;
  logic             refresh_ack;
  logic             refresh_pending;
  logic [GAP_W-1:0] gap_cnt;
  logic [GAP_W-1:0] gap_load;
  logic             gap_done;
  logic             last_write;

  assign refresh_pending = strobe_q ^ refresh_ack;   // Toggle not yet served

  // ------------------------------
  // Command choice
  // ------------------------------
  always_comb
  begin
    if (refresh_pending && page_open)
      next_cmd = PRCH;
    else if (refresh_pending)
      next_cmd = ARSR;
    else if (sel_valid && page_hit)
      next_cmd = sel_we ? WRTE : READ;
    else if (sel_valid && page_open)
      next_cmd = PRCH;
    else if (sel_valid)
      next_cmd = ACTV;
    else
      next_cmd = NOOP;
  end

  // A write leaves T_WR before PRCH but only T_RW before another access
  always_comb
  begin
    if (last_write && (next_cmd != PRCH))
      gap_done = gap_cnt <= GAP_W'(`T_WR - `T_RW);
    else
      gap_done = gap_cnt == '0;
  end

  always_comb
  begin
    case (next_cmd)
      ACTV:    gap_load = GAP_W'(`T_RCD);
      PRCH:    gap_load = GAP_W'(`T_RP);
      ARSR:    gap_load = GAP_W'(`T_RFC);
      WRTE:    gap_load = GAP_W'(`T_WR);
      READ:    gap_load = GAP_W'(`T_RW);
      default: gap_load = '0;
    endcase
  end

  assign issue      = gap_done && (next_cmd != NOOP);
  assign issue_bulk = sel_bulk;

  // ------------------------------
  // Bus address and bank
  // ------------------------------
  always_comb
  begin
    case (next_cmd)
      ACTV:       next_addr = {1'b0, sel_addr.fields.row};
      READ, WRTE: next_addr = {sel_addr.fields.column, 1'b0};
      default:    next_addr = `PRECHARGE_ALL_ADDR;
    endcase
  end

  always_comb
  begin
    case (next_cmd)
      ACTV:             next_bank = sel_addr.fields.bank;
      READ, WRTE, PRCH: next_bank = open_page[`BANK_W-1:0];
      default:          next_bank = '0;
    endcase
  end

  // ------------------------------
  // Bank and refresh state
  // ------------------------------
  always_ff @(posedge INPUT_CLK)
  begin
    if (!RST)
    begin
      strobe_q    <= refresh_strobe;
      refresh_ack <= refresh_strobe;   // Nothing owed out of reset
      gap_cnt     <= '0;
      last_write  <= 1'b0;
      page_open   <= 1'b0;
    end
    else
    begin
      strobe_q <= refresh_strobe;
      if (issue)
      begin
        gap_cnt    <= gap_load;
        last_write <= (next_cmd == WRTE);
        if (next_cmd == ACTV)
          page_open <= 1'b1;
        if (next_cmd == PRCH)
          page_open <= 1'b0;
        if (next_cmd == ARSR)
          refresh_ack <= strobe_q;
      end
      else if (gap_cnt != '0)
        gap_cnt <= gap_cnt - 1'b1;
    end
  end

  always_ff @(posedge INPUT_CLK)
  begin
    if (issue && (next_cmd == ACTV))
      open_page <= sel_addr.paged.page;
  end

endmodule

`default_nettype wire

// File: verilog/sdram_command_result.sv
`timescale 1ns/1ps
`default_nettype none
`include "sdram_params.svh"

module sdram_command_result
  import sdram_pkg::*;
(
  input  wire                    INPUT_CLK,
  input  wire                    RST,
  input  wire                    issue,
  input  wire sdram_cmd_t        next_cmd,
  input  wire [`CMD_ADDR_W-1:0]  next_addr,
  input  wire [`BANK_W-1:0]      next_bank,
  input  wire                    issue_bulk,
  output sdram_cmd_t             cmd,
  output logic [`CMD_ADDR_W-1:0] cmd_addr,
  output logic [`BANK_W-1:0]     cmd_bank,
  output logic                   rand_ready,
  output logic                   bulk_ready
);

  logic grant;

  assign grant = issue && ((next_cmd == READ) || (next_cmd == WRTE));

  always_ff @(posedge INPUT_CLK)
  begin
    if (!RST)
    begin
      cmd        <= NOOP;
      cmd_addr   <= `PRECHARGE_ALL_ADDR;
      cmd_bank   <= '0;
      rand_ready <= 1'b0;
      bulk_ready <= 1'b0;
    end
    else
    begin
      if (issue)
      begin
        cmd      <= next_cmd;
        cmd_addr <= next_addr;
        cmd_bank <= next_bank;
      end
      else
      begin
        cmd      <= NOOP;
        cmd_addr <= `PRECHARGE_ALL_ADDR;   // Bank held from last command
      end
      rand_ready <= grant && !issue_bulk;
      bulk_ready <= grant && issue_bulk;
    end
  end

endmodule

`default_nettype wire

// File: verilog/sdram_params.svh
`ifndef SDRAM_PARAMS_SVH
`define SDRAM_PARAMS_SVH

// ------------------------------
// Request address fields
// ------------------------------
`define ADDR_W              26
`define ROW_W               12
`define BANK_W              2
`define COL_W               12
`define PAGE_W              14

// SDRAM address bus
`define CMD_ADDR_W          13
`define PRECHARGE_ALL_ADDR  13'h0400   // Only A10 set

// ------------------------------
// Idle cycles after a command
// ------------------------------
`define T_RCD               3          // ACTV to READ/WRTE
`define T_RP                3          // PRCH to next command
`define T_RFC               10         // ARSR to next command
`define T_RW                2          // READ/WRTE to next command
`define T_WR                4          // WRTE to PRCH

`endif

// File: verilog/sdram_pkg.sv
`default_nettype none
`include "sdram_params.svh"

package sdram_pkg;

  // SDRAM command pins, {RAS, CAS, WE}
  typedef enum logic [2:0] {
    MRST = 3'b000,
    ARSR = 3'b001,   // Auto refresh
    PRCH = 3'b010,   // Row close
    ACTV = 3'b011,   // Row open
    WRTE = 3'b100,
    READ = 3'b101,
    BTRM = 3'b110,
    NOOP = 3'b111
  } sdram_cmd_t;

  typedef struct packed {
    logic [`ROW_W-1:0]  row;
    logic [`BANK_W-1:0] bank;
    logic [`COL_W-1:0]  column;
  } req_fields_t;

  typedef struct packed {
    logic [`PAGE_W-1:0] page;     // Row and bank as one tag
    logic [`COL_W-1:0]  column;
  } req_page_t;

  typedef union packed {
    req_fields_t fields;
    req_page_t   paged;
  } req_addr_t;

endpackage

`default_nettype wire

// File: verilog/sdram_request_decode.sv
`timescale 1ns/1ps
`default_nettype none
`include "sdram_params.svh"

module sdram_request_decode
  import sdram_pkg::*;
(
  input  wire                INPUT_CLK,
  input  wire                RST,
  input  wire                rand_valid,
  input  wire                rand_we,
  input  wire req_addr_t     rand_addr,
  input  wire                bulk_valid,
  input  wire                bulk_we,
  input  wire req_addr_t     bulk_addr,
  input  wire [`PAGE_W-1:0]  open_page,
  input  wire                page_open,
  output logic               sel_valid,
  output logic               sel_bulk,
  output logic               sel_we,
  output req_addr_t          sel_addr,
  output logic               page_hit
);

  logic      rand_valid_q;
  logic      bulk_valid_q;
  logic      rand_we_q;
  logic      bulk_we_q;
  req_addr_t rand_addr_q;
  req_addr_t bulk_addr_q;

  // ------------------------------
  // Port registers
  // ------------------------------
  always_ff @(posedge INPUT_CLK)
  begin
    if (!RST)
    begin
      rand_valid_q <= 1'b0;
      bulk_valid_q <= 1'b0;
    end
    else
    begin
      rand_valid_q <= rand_valid;
      bulk_valid_q <= bulk_valid;
    end
  end

  always_ff @(posedge INPUT_CLK)
  begin
    rand_we_q   <= rand_we;
    rand_addr_q <= rand_addr;
    bulk_we_q   <= bulk_we;
    bulk_addr_q <= bulk_addr;
  end

  // ------------------------------
  // Arbitration, bulk first
  // ------------------------------
  assign sel_valid = rand_valid_q || bulk_valid_q;
  assign sel_bulk  = bulk_valid_q;
  assign sel_addr  = bulk_valid_q ? bulk_addr_q : rand_addr_q;
  assign sel_we    = bulk_valid_q ? bulk_we_q : rand_we_q;

  // Open-page hit on the page view
  assign page_hit = sel_valid && page_open && (sel_addr.paged.page == open_page);

endmodule

`default_nettype wire

// File: verilog/sdram_scheduler.sv
`timescale 1ns/1ps
`default_nettype none
`include "sdram_params.svh"

module sdram_scheduler
  import sdram_pkg::*;
(
  input  wire                    INPUT_CLK,
  input  wire                    RST,
  input  wire                    refresh_strobe,
  // Random port
  input  wire                    rand_valid,
  input  wire req_addr_t         rand_addr,
  input  wire                    rand_we,
  output logic                   rand_ready,
  // Bulk port
  input  wire                    bulk_valid,
  input  wire req_addr_t         bulk_addr,
  input  wire                    bulk_we,
  output logic                   bulk_ready,
  // SDRAM command side
  output sdram_cmd_t             cmd,
  output logic [`CMD_ADDR_W-1:0] cmd_addr,
  output logic [`BANK_W-1:0]     cmd_bank
);

  logic                   sel_valid;
  logic                   sel_bulk;
  logic                   sel_we;
  logic                   page_hit;
  req_addr_t              sel_addr;
  logic [`PAGE_W-1:0]     open_page;
  logic                   page_open;
  logic                   issue;
  logic                   issue_bulk;
  sdram_cmd_t             next_cmd;
  logic [`CMD_ADDR_W-1:0] next_addr;
  logic [`BANK_W-1:0]     next_bank;

  sdram_request_decode u_decode (
    .INPUT_CLK  (INPUT_CLK),
    .RST        (RST),
    .rand_valid (rand_valid),
    .rand_we    (rand_we),
    .rand_addr  (rand_addr),
    .bulk_valid (bulk_valid),
    .bulk_we    (bulk_we),
    .bulk_addr  (bulk_addr),
    .open_page  (open_page),
    .page_open  (page_open),
    .sel_valid  (sel_valid),
    .sel_bulk   (sel_bulk),
    .sel_we     (sel_we),
    .sel_addr   (sel_addr),
    .page_hit   (page_hit)
  );

  sdram_command_execute u_execute (
    .INPUT_CLK      (INPUT_CLK),
    .RST            (RST),
    .refresh_strobe (refresh_strobe),
    .sel_valid      (sel_valid),
    .sel_bulk       (sel_bulk),
    .sel_we         (sel_we),
    .page_hit       (page_hit),
    .sel_addr       (sel_addr),
    .issue          (issue),
    .next_cmd       (next_cmd),
    .next_addr      (next_addr),
    .next_bank      (next_bank),
    .open_page      (open_page),
    .page_open      (page_open),
    .issue_bulk     (issue_bulk)
  );

  sdram_command_result u_result (
    .INPUT_CLK  (INPUT_CLK),
    .RST        (RST),
    .issue      (issue),
    .next_cmd   (next_cmd),
    .next_addr  (next_addr),
    .next_bank  (next_bank),
    .issue_bulk (issue_bulk),
    .cmd        (cmd),
    .cmd_addr   (cmd_addr),
    .cmd_bank   (cmd_bank),
    .rand_ready (rand_ready),
    .bulk_ready (bulk_ready)
  );

endmodule

`default_nettype wire
